//--- cart_loader_pkg.sv
package cart_loader_pkg;

	// ==================================================
	// Download stream
	// ==================================================

	typedef logic [15:0] word_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;

	// All-ones file index carries cheat codes
	localparam dl_index_t CODE_INDEX = 8'hFF;

	// ==================================================
	// Cartridge header
	// ==================================================

	typedef logic [23:0] mask_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [7:0]  rom_type_t;
	typedef logic [2:0]  header_mode_t;
	typedef logic [1:0]  region_sel_t;

	localparam header_mode_t HDR_AUTO    = 3'd0;
	localparam header_mode_t HDR_NONE    = 3'd1;
	localparam header_mode_t HDR_LOROM   = 3'd2;
	localparam header_mode_t HDR_HIROM   = 3'd3;
	localparam header_mode_t HDR_EXHIROM = 3'd4;

	localparam region_sel_t REGION_AUTO = 2'd0;

	// Copier header sits in front of the ROM image
	localparam dl_addr_t COPIER_HDR_BYTES  = 25'h200;

	// ROM size word per mapping; RAM size word is two bytes above
	localparam dl_addr_t LOROM_INFO_ADDR   = 25'h007FD6 + COPIER_HDR_BYTES;
	localparam dl_addr_t HIROM_INFO_ADDR   = 25'h00FFD6 + COPIER_HDR_BYTES;
	localparam dl_addr_t EXHIROM_INFO_ADDR = 25'h40FFD6 + COPIER_HDR_BYTES;

	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;
	localparam mask_t      MASK_UNIT        = 24'd1024;

	// ==================================================
	// Cheat codes and work-RAM fill
	// ==================================================

	// {strobe, flags, address, compare, replace}
	typedef logic [128:0] cheat_code_t;

	typedef logic [16:0] fill_addr_t;
	typedef logic [1:0]  fill_sel_t;

	localparam fill_sel_t FILL_SNES1 = 2'd0;
	localparam fill_sel_t FILL_SNES2 = 2'd1;
	localparam fill_sel_t FILL_55    = 2'd2;
	localparam fill_sel_t FILL_FF    = 2'd3;

endpackage

//--- download_decode.sv
`timescale 1ns/1ps

module download_decode (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       dl_active,
	input  cart_loader_pkg::dl_index_t dl_index,
	output logic                       cart_dl,
	output logic                       code_dl,
	output logic                       cart_start
);

	import cart_loader_pkg::*;

	logic code_index;
	logic cart_dl_q;

	// Cheat files use the reserved index, everything else is a cartridge
	assign code_index = (dl_index == CODE_INDEX);
	assign code_dl    = dl_active & code_index;
	assign cart_dl    = dl_active & ~code_index;

	// Previous cartridge state for the start edge
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_dl_q <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;
		end
	end

	// First cycle of a cartridge download
	assign cart_start = cart_dl & ~cart_dl_q;

endmodule

//--- rom_header_parse.sv
`timescale 1ns/1ps

module rom_header_parse (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_dl,
	input  logic                          dl_wr,
	input  cart_loader_pkg::dl_addr_t     dl_addr,
	input  cart_loader_pkg::word_t        dl_data,
	input  cart_loader_pkg::header_mode_t header_mode,
	input  cart_loader_pkg::region_sel_t  region_sel,
	output cart_loader_pkg::rom_type_t    rom_type,
	output cart_loader_pkg::mask_t        rom_mask,
	output cart_loader_pkg::mask_t        ram_mask,
	output logic                          pal
);

	import cart_loader_pkg::*;

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;
	dl_addr_t   info_addr;
	logic       info_en;
	logic       hdr_wr;

	assign hdr_wr = cart_dl & dl_wr;

	// ==================================================
	// Info word location for the forced mappings
	// ==================================================

	always_comb begin
		info_en   = 1'b1;
		info_addr = '0;
		case (header_mode)
			HDR_LOROM:   info_addr = LOROM_INFO_ADDR;
			HDR_HIROM:   info_addr = HIROM_INFO_ADDR;
			HDR_EXHIROM: info_addr = EXHIROM_INFO_ADDR;
			default:     info_en   = 1'b0;
		endcase
	end

	// ==================================================
	// Header capture
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (dl_addr == '0) begin
				// Auto mode reads sizes packed into the first byte
				if (header_mode == HDR_AUTO && dl_data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= dl_data[7:0];
				end else begin
					rom_size <= DEFAULT_ROM_SIZE;
					ram_size <= '0;
				end

				case (header_mode)
					HDR_NONE,
					HDR_LOROM:   rom_type <= 8'd0;
					HDR_HIROM:   rom_type <= 8'd1;
					HDR_EXHIROM: rom_type <= 8'd2;
					default:     rom_type <= dl_data[15:8];
				endcase
			end

			if (dl_addr == 25'd2) begin
				rom_region <= dl_data[8];
			end

			if (info_en && dl_addr == info_addr) begin
				rom_size <= dl_data[11:8];
			end
			if (info_en && dl_addr == info_addr + 25'd2) begin
				ram_size <= dl_data[3:0];
			end
		end
	end

	// Masks follow the registered size codes
	assign rom_mask = (MASK_UNIT << rom_size) - 1'b1;
	assign ram_mask = (ram_size != '0) ? (MASK_UNIT << ram_size) - 1'b1 : '0;

	// Video standard only switches outside a download
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_dl) begin
			pal <= (region_sel == REGION_AUTO) ? rom_region : region_sel[1];
		end
	end

endmodule

//--- cheat_code_assemble.sv
`timescale 1ns/1ps

module cheat_code_assemble (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         code_dl,
	input  logic                         dl_wr,
	input  cart_loader_pkg::dl_addr_t    dl_addr,
	input  cart_loader_pkg::word_t       dl_data,
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic                         code_valid
);

	import cart_loader_pkg::*;

	logic [127:0] code_body;
	logic         code_strobe;

	// Strobe stays high only for the cycle after the last word
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_strobe <= 1'b0;
		end else begin
			code_strobe <= code_dl & dl_wr & (dl_addr[3:0] == 4'd14);
		end
	end

	// Word slots within a 16-byte record
	always_ff @(posedge clk_sys) begin
		if (code_dl && dl_wr) begin
			case (dl_addr[3:0])
				4'd0:  code_body[111:96]  <= dl_data;
				4'd2:  code_body[127:112] <= dl_data;
				4'd4:  code_body[79:64]   <= dl_data;
				4'd6:  code_body[95:80]   <= dl_data;
				4'd8:  code_body[47:32]   <= dl_data;
				4'd10: code_body[63:48]   <= dl_data;
				4'd12: code_body[15:0]    <= dl_data;
				// Replace high word closes the record
				4'd14: code_body[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	assign cheat_code = cheat_code_t'({code_strobe, code_body});
	assign code_valid = code_strobe;

endmodule

//--- ram_clear_fill.sv
`timescale 1ns/1ps

module ram_clear_fill (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        cart_dl,
	input  logic                        cart_start,
	input  cart_loader_pkg::fill_sel_t  fill_sel,
	output cart_loader_pkg::fill_addr_t fill_addr,
	output logic [7:0]                  fill_data,
	output logic                        fill_we,
	output logic                        clearing,
	output logic                        core_hold
);

	import cart_loader_pkg::*;

	// ==================================================
	// Address sweep
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else if (cart_start) begin
			clearing  <= 1'b1;
			fill_addr <= '0;
		end else if (clearing) begin
			fill_addr <= fill_addr + 1'b1;
			// Last write lands at the top address
			if (&fill_addr) begin
				clearing <= 1'b0;
			end
		end
	end

	assign fill_we = clearing;

	// Power-on patterns of the different console revisions
	always_comb begin
		case (fill_sel)
			FILL_SNES1: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_SNES2: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			FILL_55:    fill_data = 8'h55;
			FILL_FF:    fill_data = 8'hFF;
			default:    fill_data = 8'hFF;
		endcase
	end

	// Core waits for both the image and the clean work RAM
	assign core_hold = RESET | cart_dl | clearing;

endmodule

//--- cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          dl_active,
	input  cart_loader_pkg::dl_index_t    dl_index,
	input  cart_loader_pkg::dl_addr_t     dl_addr,
	input  cart_loader_pkg::word_t        dl_data,
	input  logic                          dl_wr,
	input  cart_loader_pkg::header_mode_t header_mode,
	input  cart_loader_pkg::region_sel_t  region_sel,
	input  cart_loader_pkg::fill_sel_t    fill_sel,
	output cart_loader_pkg::rom_type_t    rom_type,
	output cart_loader_pkg::mask_t        rom_mask,
	output cart_loader_pkg::mask_t        ram_mask,
	output logic                          pal,
	output cart_loader_pkg::cheat_code_t  cheat_code,
	output logic                          code_valid,
	output cart_loader_pkg::fill_addr_t   fill_addr,
	output logic [7:0]                    fill_data,
	output logic                          fill_we,
	output logic                          clearing,
	output logic                          core_hold
);

	logic cart_dl;
	logic code_dl;
	logic cart_start;

	// ==================================================
	// Stream decode
	// ==================================================

	download_decode u_decode (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cart_start (cart_start)
	);

	// ==================================================
	// Header and cheat interpretation
	// ==================================================

	rom_header_parse u_header (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_dl     (cart_dl),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_code_assemble u_cheat (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.code_dl    (code_dl),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.cheat_code (cheat_code),
		.code_valid (code_valid)
	);

	// Work-RAM clear after each cartridge
	ram_clear_fill u_fill (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_dl    (cart_dl),
		.cart_start (cart_start),
		.fill_sel   (fill_sel),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we),
		.clearing   (clearing),
		.core_hold  (core_hold)
	);

endmodule

//--- cart_loader_checker.sv
`timescale 1ns/1ps

module cart_loader_checker (
	input  logic                         clk_sys,
	input  logic                         RESET,
	input  logic                         dl_active,
	input  cart_loader_pkg::dl_index_t   dl_index,
	input  cart_loader_pkg::dl_addr_t    dl_addr,
	input  logic                         dl_wr,
	input  cart_loader_pkg::fill_sel_t   fill_sel,
	input  cart_loader_pkg::rom_type_t   rom_type,
	input  cart_loader_pkg::mask_t       rom_mask,
	input  cart_loader_pkg::mask_t       ram_mask,
	input  logic                         pal,
	input  cart_loader_pkg::cheat_code_t cheat_code,
	input  logic                         code_valid,
	input  cart_loader_pkg::fill_addr_t  fill_addr,
	input  logic [7:0]                   fill_data,
	input  logic                         fill_we,
	input  logic                         clearing,
	input  logic                         core_hold,
	input  logic                         check_cart,
	input  logic                         check_code,
	input  logic [127:0]                 exp_fields,
	output int                           checks,
	output int                           errors
);

	import cart_loader_pkg::*;

	int         valid_count;
	logic       want_valid;
	logic       cart_now;
	logic       cart_dl_q;
	logic       pal_q;
	logic       exp_clear;
	fill_addr_t exp_addr;

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %0t ns %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// Power-on byte for each fill pattern
	function automatic logic [7:0] expected_fill(input fill_sel_t sel, input fill_addr_t a);
		case (sel)
			2'd0:    expected_fill = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd1:    expected_fill = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd2:    expected_fill = 8'h55;
			default: expected_fill = 8'hFF;
		endcase
	endfunction

	initial begin
		checks      = 0;
		errors      = 0;
		valid_count = 0;
		want_valid  = 1'b0;
		cart_dl_q   = 1'b0;
		exp_clear   = 1'b0;
		exp_addr    = '0;
	end

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		cart_now = dl_active && (dl_index != CODE_INDEX);
		check_value("core_hold", RESET | cart_now | exp_clear, core_hold);
		if (!RESET) begin
			check_value("code_valid", want_valid, code_valid);
			if (code_valid) begin
				valid_count++;
				check_value("cheat_code", {1'b1, exp_fields}, cheat_code);
			end
			if (pal !== pal_q && cart_dl_q) begin
				errors++;
				$display("pal changed at %0t ns while a cartridge was downloading", $time);
			end

			// ==================================================
			// Work-RAM sweep
			// ==================================================
			check_value("clearing", exp_clear, clearing);
			check_value("fill_we", exp_clear, fill_we);
			if (exp_clear) begin
				check_value("fill_addr", exp_addr, fill_addr);
				check_value("fill_data", expected_fill(fill_sel, exp_addr), fill_data);
			end

			if (check_cart) begin
				check_value("rom_type", exp_fields[127:96], rom_type);
				check_value("rom_mask", exp_fields[95:64], rom_mask);
				check_value("ram_mask", exp_fields[63:32], ram_mask);
				check_value("pal", exp_fields[31:0], pal);
			end
			if (check_code) begin
				check_value("code_valid pulses", 1, valid_count);
				valid_count = 0;
			end
		end
		// Strobe at offset 14 must show as code_valid one cycle later
		want_valid = dl_active && (dl_index == CODE_INDEX) && dl_wr && (dl_addr[3:0] == 4'd14);
		// Sweep starts the cycle after the first cartridge word
		if (RESET) begin
			exp_clear = 1'b0;
		end else if (cart_now && !cart_dl_q) begin
			exp_clear = 1'b1;
			exp_addr  = '0;
		end else if (exp_clear) begin
			if (&exp_addr) begin
				exp_clear = 1'b0;
			end
			exp_addr = exp_addr + 1'b1;
		end
		cart_dl_q  = cart_now;
		pal_q      = pal;
	end

endmodule

//--- cart_loader_tb.sv
`timescale 1ns/1ps

module cart_loader_tb;

	import cart_loader_pkg::*;

	localparam int NUM_TESTS   = 6;
	localparam int REC_WORDS   = 15;
	localparam int MAX_WRITES  = 8;
	localparam int CYCLE_LIMIT = NUM_TESTS * (131072 + 4 * MAX_WRITES) + 1000;

	logic         clk_sys;
	logic         RESET;
	logic         dl_active;
	dl_index_t    dl_index;
	dl_addr_t     dl_addr;
	word_t        dl_data;
	logic         dl_wr;
	header_mode_t header_mode;
	region_sel_t  region_sel;
	fill_sel_t    fill_sel;
	rom_type_t    rom_type;
	mask_t        rom_mask;
	mask_t        ram_mask;
	logic         pal;
	cheat_code_t  cheat_code;
	logic         code_valid;
	fill_addr_t   fill_addr;
	logic [7:0]   fill_data;
	logic         fill_we;
	logic         clearing;
	logic         core_hold;
	logic         check_cart;
	logic         check_code;
	logic [127:0] exp_fields;
	int           checks;
	int           errors;
	int           load_errors;
	int           cycle_count;
	integer       seed;
	logic [63:0]  test_mem [0:NUM_TESTS*REC_WORDS-1];

	cart_loader_top DUT (.*);

	cart_loader_checker u_checker (.*);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	task automatic next_cycle;
		@(posedge clk_sys);
		#2;
	endtask

	// One strobe per cycle, no back-pressure
	task automatic write_word(input dl_addr_t addr, input word_t data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		next_cycle;
		dl_wr   = 1'b0;
	endtask

	task automatic run_record(input int t);
		int          base;
		int          i;
		logic [63:0] wr;
		logic [31:0] rnd;
		base        = t * REC_WORDS;
		header_mode = test_mem[base + 1][10:8];
		region_sel  = test_mem[base + 1][5:4];
		fill_sel    = test_mem[base + 1][1:0];
		exp_fields  = {test_mem[base + 11][31:0], test_mem[base + 12][31:0],
			test_mem[base + 13][31:0], test_mem[base + 14][31:0]};
		dl_index    = (test_mem[base] == 64'd0) ? 8'h00 : CODE_INDEX;
		dl_active   = 1'b1;
		for (i = 0; i < int'(test_mem[base + 2]); i++) begin
			wr = test_mem[base + 3 + i];
			write_word(wr[40:16], wr[15:0]);
			// Filler word just past each header word
			if (test_mem[base] == 64'd0) begin
				rnd = $random(seed);
				write_word(wr[40:16] + 25'd4, rnd[15:0]);
			end
		end
		dl_active = 1'b0;
		if (test_mem[base] == 64'd0) begin
			while (clearing) begin
				next_cycle;
			end
			check_cart = 1'b1;
		end else begin
			next_cycle;
			check_code = 1'b1;
		end
		next_cycle;
		check_cart = 1'b0;
		check_code = 1'b0;
	endtask

	// Cycle budget covers one full clear per test
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles", cycle_count);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int t;
		seed        = 32'h68cd;
		load_errors = 0;
		RESET       = 1'b1;
		dl_active   = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		dl_wr       = 1'b0;
		header_mode = '0;
		region_sel  = '0;
		fill_sel    = '0;
		check_cart  = 1'b0;
		check_code  = 1'b0;
		exp_fields  = '0;
		$readmemh("cart_loader_testdata.txt", test_mem);
		repeat (8) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		next_cycle;
		if ($isunknown(test_mem[NUM_TESTS*REC_WORDS-1])) begin
			load_errors++;
			$display("Test data file is missing or shorter than expected");
		end else begin
			for (t = 0; t < NUM_TESTS; t++) begin
				run_record(t);
			end
		end
		repeat (4) next_cycle;
		$display("Checks %0d, errors %0d, load errors %0d", checks, errors, load_errors);
		if (errors == 0 && load_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- cart_loader_testdata.txt
// Line 1: kind (0 cart, 1 cheat), settings {mode[10:8], region[5:4], fill[1:0]}, count,
//         8 writes as {addr, data[15:0]}. Line 2: rom_type rom_mask ram_mask pal, or cheat fields
0 000 2 2a3b 20100 0 0 0 0 0 0
2a 1fffff 1fff 1
0 011 2 0500 20100 0 0 0 0 0 0
5 3fffff 0 0
0 222 4 1234 81d60a00 81d80005 101d60f00 0 0 0 0
0 fffff 7fff 1
1 000 8 0001 2dead 40123 6007e 80042 a0000 c00ff e0000
dead0001 7e0123 42 ff
0 403 5 ffff 20000 81d60c00 4101d60900 4101d80001 0 0 0
2 7ffff 7ff 0
0 330 3 0 101d60800 101d80000 0 0 0 0 0
1 3ffff 0 1

//--- verilog.f
cart_loader_pkg.sv
download_decode.sv
rom_header_parse.sv
cheat_code_assemble.sv
ram_clear_fill.sv
cart_loader_top.sv
cart_loader_checker.sv
cart_loader_tb.sv
